//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := exec_stage_tb
FILELIST := build.f
LOG      := sim.log

SOURCES  := $(filter-out +%,$(shell cat $(FILELIST)))
BIN      := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@grep -q "All tests passed" $(LOG) && ! grep -q "Some tests failed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- build.f
hdl/exec_pkg.sv
hdl/muldiv_if.sv
hdl/exec_alu.sv
hdl/iter_multiplier.sv
hdl/iter_divider.sv
hdl/exec_stage_top.sv
tests/exec_stage_properties.sv
tests/exec_stage_tb.sv

//--- hdl/exec_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exec_alu import exec_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            flush,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] rs1,
    input  logic [xlen-1:0] rs2,
    input  logic [xlen-1:0] csr,
    input  logic [xlen-1:0] imm,
    input  alu_op_e         op,
    input  sel_a_e          sel_a,
    input  sel_b_e          sel_b,
    input  logic            word_op,
    output logic [xlen-1:0] res,
    output logic            busy,
    muldiv_if.requester     mul_port,
    muldiv_if.requester     div_port
);

    logic [xlen-1:0]    a;
    logic [xlen-1:0]    b;
    logic [shamt_w-1:0] shamt;
    logic [xlen-1:0]    sra_d;
    logic [word_w-1:0]  sra_w;
    logic               lt_s;
    logic               lt_u;
    logic [xlen-1:0]    alu_res;
    logic [xlen-1:0]    unit_res;
    logic               is_mul;
    logic               is_div;
    logic               unit_done;
    logic               completed;  // result delivered, hold until op changes
    logic               mul_start;
    logic               div_start;

    assign a = (sel_a == sel_a_rs1) ? (word_op ? {{word_w{1'b0}}, rs1[word_w-1:0]} : rs1) : pc;

    always_comb begin
        case (sel_b)
            sel_b_rs2: b = rs2;
            sel_b_csr: b = csr;
            default:   b = imm;
        endcase
    end

    assign shamt = b[shamt_w-1:0];
    assign sra_d = $signed(a) >>> shamt;
    assign sra_w = $signed(a[word_w-1:0]) >>> shamt;
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            op_add:    alu_res = a + b;
            op_sub:    alu_res = a - b;
            op_pass_a: alu_res = a;
            op_pass_b: alu_res = b;
            op_xor:    alu_res = a ^ b;
            op_or:     alu_res = a | b;
            op_and:    alu_res = a & b;
            op_sll:    alu_res = a << shamt;
            op_srl:    alu_res = a >> shamt;
            op_sra:    alu_res = word_op ? {{word_w{1'b0}}, sra_w} : sra_d;
            op_slt:    alu_res = {{(xlen-1){1'b0}}, lt_s};
            op_sltu:   alu_res = {{(xlen-1){1'b0}}, lt_u};
            op_eq:     alu_res = {{(xlen-1){1'b0}}, a == b};
            op_ge:     alu_res = {{(xlen-1){1'b0}}, ~lt_s};
            op_geu:    alu_res = {{(xlen-1){1'b0}}, ~lt_u};
            default:   alu_res = '0;  // multi-cycle ops come from the units
        endcase
    end

    assign is_mul = op inside {op_mul, op_mulhu};
    assign is_div = op inside {op_div, op_divu, op_rem, op_remu};
    assign unit_done = is_mul ? mul_port.done : div_port.done;

    always_comb begin
        case (op)
            op_mul:          unit_res = mul_port.result;
            op_mulhu:        unit_res = mul_port.result_aux;
            op_div, op_divu: unit_res = div_port.result;
            default:         unit_res = div_port.result_aux;
        endcase
    end

    // operands go straight through, units latch them at start
    assign mul_port.start     = mul_start;
    assign mul_port.op_a      = a;
    assign mul_port.op_b      = b;
    assign mul_port.is_signed = 1'b0;
    assign mul_port.flush     = flush;

    assign div_port.start     = div_start;
    assign div_port.op_a      = a;
    assign div_port.op_b      = b;
    assign div_port.is_signed = (op == op_div) || (op == op_rem);
    assign div_port.flush     = flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res       <= '0;
            busy      <= 1'b0;
            completed <= 1'b0;
            mul_start <= 1'b0;
            div_start <= 1'b0;
        end else begin
            mul_start <= 1'b0;
            div_start <= 1'b0;
            if (flush) begin
                busy      <= 1'b0;  // res keeps its old value
                completed <= 1'b0;
            end else if (is_mul || is_div) begin
                if (busy) begin
                    if (unit_done) begin
                        res       <= unit_res;
                        busy      <= 1'b0;
                        completed <= 1'b1;
                    end
                end else if (!completed) begin
                    busy      <= 1'b1;
                    mul_start <= is_mul;
                    div_start <= is_div;
                end
            end else begin
                res       <= alu_res;
                busy      <= 1'b0;
                completed <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int xlen = 64;
    localparam int word_w = 32;    // low half used by word mode
    localparam int shamt_w = 6;
    localparam int iter_steps = 64;  // one quotient or product bit per step
    localparam int cnt_w = 7;        // counts 0..iter_steps

    typedef enum logic [4:0] {
        op_add,
        op_sub,
        op_pass_a,
        op_pass_b,
        op_xor,
        op_or,
        op_and,
        op_sll,
        op_srl,
        op_sra,
        op_slt,
        op_sltu,
        op_eq,
        op_ge,
        op_geu,
        op_mul,
        op_mulhu,
        op_div,
        op_divu,
        op_rem,
        op_remu
    } alu_op_e;

    typedef enum logic {
        sel_a_pc,
        sel_a_rs1
    } sel_a_e;

    typedef enum logic [1:0] {
        sel_b_imm,
        sel_b_rs2,
        sel_b_csr
    } sel_b_e;

    typedef enum logic {
        st_idle,
        st_run
    } unit_state_e;

endpackage

`default_nettype wire

//--- hdl/exec_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage_top import exec_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            flush,
    input  logic [xlen-1:0] pc,
    input  alu_op_e         op,
    input  logic [xlen-1:0] rs1,
    input  logic [xlen-1:0] rs2,
    input  logic [xlen-1:0] csr,
    input  logic [xlen-1:0] imm,
    input  sel_a_e          sel_a,
    input  sel_b_e          sel_b,
    input  logic            word_op,
    output logic [xlen-1:0] res,
    output logic            busy
);

    muldiv_if mul_if ();
    muldiv_if div_if ();

    exec_alu exec_alu_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .pc       (pc),
        .rs1      (rs1),
        .rs2      (rs2),
        .csr      (csr),
        .imm      (imm),
        .op       (op),
        .sel_a    (sel_a),
        .sel_b    (sel_b),
        .word_op  (word_op),
        .res      (res),
        .busy     (busy),
        .mul_port (mul_if.requester),
        .div_port (div_if.requester)
    );

    iter_multiplier iter_multiplier_i (
        .clk    (clk),
        .arst_n (arst_n),
        .port   (mul_if.unit)
    );

    iter_divider iter_divider_i (
        .clk    (clk),
        .arst_n (arst_n),
        .port   (div_if.unit)
    );

endmodule

`default_nettype wire

//--- hdl/iter_divider.sv
`timescale 1ns/1ps
`default_nettype none

module iter_divider import exec_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    muldiv_if.unit port
);

    unit_state_e       state;
    logic [cnt_w-1:0]  cnt;
    logic [xlen-1:0]   quo;      // dividend bits out, quotient bits in
    logic [xlen-1:0]   rem;
    logic [xlen-1:0]   divisor;
    logic              neg_q;
    logic              neg_r;
    logic              a_neg;
    logic              b_neg;
    logic [xlen:0]     shifted;
    logic [xlen:0]     trial;
    logic              last;

    assign a_neg = port.is_signed & port.op_a[xlen-1];
    assign b_neg = port.is_signed & port.op_b[xlen-1];
    assign last  = (cnt == cnt_w'(iter_steps));

    assign shifted = {rem, quo[xlen-1]};
    assign trial   = shifted - {1'b0, divisor};  // msb set means borrow

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            cnt       <= '0;
            port.done <= 1'b0;
        end else begin
            port.done <= 1'b0;
            if (port.flush) begin
                state <= st_idle;
            end else begin
                case (state)
                    st_idle: begin
                        if (port.start) begin
                            state <= st_run;
                            cnt   <= '0;
                        end
                    end
                    st_run: begin
                        if (last) begin
                            state     <= st_idle;
                            port.done <= 1'b1;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    // zero divisor gives all ones and the dividend without special steps,
    // so only the quotient sign fix has to be skipped for it
    always_ff @(posedge clk) begin
        if (state == st_idle && port.start) begin
            quo     <= a_neg ? -port.op_a : port.op_a;
            divisor <= b_neg ? -port.op_b : port.op_b;
            rem     <= '0;
            neg_q   <= (a_neg ^ b_neg) && (port.op_b != '0);
            neg_r   <= a_neg;
        end else if (state == st_run && !last) begin
            if (!trial[xlen]) begin
                rem <= trial[xlen-1:0];
                quo <= {quo[xlen-2:0], 1'b1};
            end else begin
                rem <= shifted[xlen-1:0];
                quo <= {quo[xlen-2:0], 1'b0};
            end
        end
    end

    assign port.result     = neg_q ? -quo : quo;
    assign port.result_aux = neg_r ? -rem : rem;  // sign of dividend

endmodule

`default_nettype wire

//--- hdl/iter_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module iter_multiplier import exec_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    muldiv_if.unit port
);

    unit_state_e        state;
    logic [cnt_w-1:0]   cnt;
    logic [xlen-1:0]    mcand;
    logic [2*xlen-1:0]  acc;   // high: partial sum, low: multiplier bits
    logic [xlen:0]      sum;
    logic               last;

    assign last = (cnt == cnt_w'(iter_steps));

    // add multiplicand when the current multiplier bit is set
    assign sum = {1'b0, acc[2*xlen-1:xlen]} + (acc[0] ? {1'b0, mcand} : '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            cnt       <= '0;
            port.done <= 1'b0;
        end else begin
            port.done <= 1'b0;
            if (port.flush) begin
                state <= st_idle;
            end else begin
                case (state)
                    st_idle: begin
                        if (port.start) begin
                            state <= st_run;
                            cnt   <= '0;
                        end
                    end
                    st_run: begin
                        if (last) begin
                            state     <= st_idle;
                            port.done <= 1'b1;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && port.start) begin
            mcand <= port.op_a;
            acc   <= {{xlen{1'b0}}, port.op_b};
        end else if (state == st_run && !last) begin
            acc <= {sum, acc[xlen-1:1]};  // shift right one bit
        end
    end

    assign port.result     = acc[xlen-1:0];
    assign port.result_aux = acc[2*xlen-1:xlen];

endmodule

`default_nettype wire

//--- hdl/muldiv_if.sv
`timescale 1ns/1ps
`default_nettype none

interface muldiv_if import exec_pkg::*; ();

    logic            start;      // one-cycle pulse
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic            is_signed;
    logic            flush;
    logic            done;       // one-cycle pulse, results valid with it
    logic [xlen-1:0] result;     // low product or quotient
    logic [xlen-1:0] result_aux; // high product or remainder

    modport requester (
        output start,
        output op_a,
        output op_b,
        output is_signed,
        output flush,
        input  done,
        input  result,
        input  result_aux
    );

    modport unit (
        input  start,
        input  op_a,
        input  op_b,
        input  is_signed,
        input  flush,
        output done,
        output result,
        output result_aux
    );

endinterface

`default_nettype wire

//--- tests/exec_stage_properties.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage_properties (
    input logic clk,
    input logic arst_n,
    input logic flush,
    input logic busy,
    input logic mul_start,
    input logic div_start,
    input logic unit_done
);

    mul_start_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        mul_start |=> !mul_start)
        else $error("mul start held longer than one cycle");

    div_start_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        div_start |=> !div_start)
        else $error("div start held longer than one cycle");

    // busy only drops on a done pulse or a flush
    busy_fall_cause: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(busy) |-> $past(unit_done || flush))
        else $error("busy fell without done or flush");

    start_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
        (mul_start || div_start) |-> !$past(busy))
        else $error("start pulsed while busy was already high");

    flush_clears_busy: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !busy)
        else $error("busy still high after flush");

endmodule

bind exec_alu exec_stage_properties exec_stage_properties_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .flush     (flush),
    .busy      (busy),
    .mul_start (mul_start),
    .div_start (div_start),
    .unit_done (unit_done)
);

`default_nettype wire

//--- tests/exec_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage_tb import exec_pkg::*; ();

    localparam int timeout_cycles = 200;

    logic            clk;
    logic            arst_n;
    logic            flush;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1;
    logic [xlen-1:0] rs2;
    logic [xlen-1:0] csr;
    logic [xlen-1:0] imm;
    alu_op_e         op;
    sel_a_e          sel_a;
    sel_b_e          sel_b;
    logic            word_op;
    logic [xlen-1:0] res;
    logic            busy;
    logic [xlen-1:0] exp_res;
    int              seed = 2058;
    int              errors = 0;
    int              checks = 0;
    event            check_ev;
    alu_op_e         unit_ops[6] = '{op_mul, op_mulhu, op_div, op_divu, op_rem, op_remu};

    exec_stage_top exec_stage_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [xlen-1:0] ref_exec(input alu_op_e o, input sel_a_e sa,
            input sel_b_e sb, input logic w, input logic [xlen-1:0] p, r1, r2, c, i);
        logic [xlen-1:0]          a;
        logic [xlen-1:0]          b;
        logic [2*xlen-1:0]        prod;
        logic signed [word_w-1:0] lo;
        logic [word_w-1:0]        sra_w;
        logic [xlen-1:0]          sra_d;
        logic [xlen-1:0]          q_s;
        logic [xlen-1:0]          r_s;
        a = (sa == sel_a_pc) ? p : (w ? {{word_w{1'b0}}, r1[word_w-1:0]} : r1);
        b = (sb == sel_b_rs2) ? r2 : ((sb == sel_b_csr) ? c : i);
        prod = {{xlen{1'b0}}, a} * {{xlen{1'b0}}, b};
        lo = a[word_w-1:0];
        sra_w = lo >>> b[shamt_w-1:0];
        sra_d = $signed(a) >>> b[shamt_w-1:0];
        if (a == {1'b1, {(xlen-1){1'b0}}} && b == '1) begin  // signed overflow
            q_s = a;
            r_s = '0;
        end else if (b != '0) begin
            q_s = $signed(a) / $signed(b);
            r_s = $signed(a) % $signed(b);
        end else begin
            q_s = '1;
            r_s = a;
        end
        case (o)
            op_add:    return a + b;
            op_sub:    return a - b;
            op_pass_a: return a;
            op_pass_b: return b;
            op_xor:    return a ^ b;
            op_or:     return a | b;
            op_and:    return a & b;
            op_sll:    return a << b[shamt_w-1:0];
            op_srl:    return a >> b[shamt_w-1:0];
            op_sra:    return w ? {{word_w{1'b0}}, sra_w} : sra_d;
            op_slt:    return {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            op_sltu:   return {{(xlen-1){1'b0}}, a < b};
            op_eq:     return {{(xlen-1){1'b0}}, a == b};
            op_ge:     return {{(xlen-1){1'b0}}, !($signed(a) < $signed(b))};
            op_geu:    return {{(xlen-1){1'b0}}, !(a < b)};
            op_mul:    return prod[xlen-1:0];
            op_mulhu:  return prod[2*xlen-1:xlen];
            op_div:    return q_s;
            op_rem:    return r_s;
            op_divu:   return (b == '0) ? '1 : a / b;
            op_remu:   return (b == '0) ? a : a % b;
            default:   return '0;
        endcase
    endfunction

    always @(check_ev) begin
        checks++;
        assert (res === exp_res) else begin
            errors++;
            $display("** Error: res = %h, expected %h, op %s", res, exp_res, op.name());
        end
        assert (busy === 1'b0) else begin
            errors++;
            $display("** Error: busy = %h, expected 0", busy);
        end
    end

    task automatic rand_operands();
        @(posedge clk);
        pc  <= {$random(seed), $random(seed)};
        rs1 <= {$random(seed), $random(seed)};
        rs2 <= {$random(seed), $random(seed)};
        csr <= {$random(seed), $random(seed)};
        imm <= {$random(seed), $random(seed)};
    endtask

    task automatic drive(input alu_op_e o, input sel_a_e sa, input sel_b_e sb, input logic w);
        @(posedge clk);
        op      <= o;
        sel_a   <= sa;
        sel_b   <= sb;
        word_op <= w;
        flush   <= 1'b0;
    endtask

    task automatic run_op(input alu_op_e o, input sel_a_e sa, input sel_b_e sb, input logic w);
        int n;
        drive(o, sa, sb, w);
        @(posedge clk);  // stage samples the new op here
        @(negedge clk);
        if (o inside {op_mul, op_mulhu, op_div, op_divu, op_rem, op_remu}) begin
            assert (busy) else begin
                errors++;
                $display("** Error: busy = %h, expected 1 after start of %s", busy, o.name());
            end
            n = 0;
            while (busy && n < timeout_cycles) begin
                @(negedge clk);
                n++;
            end
            assert (!busy) else begin
                errors++;
                $display("timed out waiting for %s to finish", o.name());
            end
        end
        exp_res = ref_exec(op, sel_a, sel_b, word_op, pc, rs1, rs2, csr, imm);
        -> check_ev;
    endtask

    initial begin : stimulus
        logic [xlen-1:0]    held;
        logic [shamt_w-1:0] sh;
        int                 n;
        arst_n  = 1'b0;
        flush   = 1'b0;
        op      = op_add;
        sel_a   = sel_a_rs1;
        sel_b   = sel_b_rs2;
        word_op = 1'b0;
        pc      = '0;
        rs1     = '0;
        rs2     = '0;
        csr     = '0;
        imm     = '0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;

        // single-cycle ops over every operand source and shift amounts 0 and 63
        for (int k = 0; k <= int'(op_geu); k++) begin
            for (int s = 0; s < 6; s++) begin
                for (int rep = 0; rep < 3; rep++) begin
                    rand_operands();
                    if (rep > 0) begin
                        sh = (rep == 1) ? '0 : '1;
                        imm[shamt_w-1:0] <= sh;
                        rs2[shamt_w-1:0] <= sh;
                        csr[shamt_w-1:0] <= sh;
                    end
                    run_op(alu_op_e'(k), sel_a_e'(s / 3), sel_b_e'(s % 3), 1'b0);
                end
            end
        end

        for (int rep = 0; rep < 8; rep++) begin
            rand_operands();
            rs1[xlen-1] <= 1'b1;  // upper half must not leak in
            run_op(op_add, sel_a_rs1, sel_b_rs2, 1'b1);
            run_op(op_sra, sel_a_rs1, sel_b_imm, 1'b1);
        end

        for (int rep = 0; rep < 8; rep++) begin
            rand_operands();
            case (rep)
                3, 4: rs2[xlen-1:word_w] <= '0;  // small divisors
                5: begin
                    rs1 <= '1;
                    rs2 <= '1;
                end
                6: rs2 <= '0;
                7: begin
                    rs1 <= {1'b1, {(xlen-1){1'b0}}};  // most negative by minus one
                    rs2 <= '1;
                end
                default: ;
            endcase
            foreach (unit_ops[u]) begin
                run_op(op_add, sel_a_rs1, sel_b_rs2, 1'b0);  // clears the completed flag
                run_op(unit_ops[u], sel_a_rs1, sel_b_rs2, 1'b0);
            end
        end

        // held opcode after completion must not restart
        held = exp_res;
        for (n = 0; n < 8; n++) begin
            @(negedge clk);
            assert (!busy && res === held) else begin
                errors++;
                $display("** Error: busy = %h, res = %h, expected res %h", busy, res, held);
            end
        end
        run_op(op_add, sel_a_rs1, sel_b_rs2, 1'b0);
        run_op(op_remu, sel_a_rs1, sel_b_rs2, 1'b0);

        rand_operands();
        run_op(op_add, sel_a_rs1, sel_b_rs2, 1'b0);
        drive(op_div, sel_a_rs1, sel_b_rs2, 1'b0);
        for (n = 0; n < 32; n++) begin
            @(negedge clk);
        end
        held = exp_res;
        assert (busy) else begin
            errors++;
            $display("** Error: busy = %h in the middle of the division, expected 1", busy);
        end
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        assert (!busy && res === held) else begin
            errors++;
            $display("** Error: busy = %h, res = %h after flush, expected res %h",
                     busy, res, held);
        end
        rand_operands();
        run_op(op_add, sel_a_rs1, sel_b_rs2, 1'b0);  // also drops flush
        run_op(op_div, sel_a_rs1, sel_b_rs2, 1'b0);

        @(posedge clk);  // last compare
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
